// File: hdl/psum_pkg.sv
package psum_pkg;

	// buffer geometry
	localparam int GLB_ADDR_W = 10;
	localparam int ROW_ADDR_W = GLB_ADDR_W - 2;
	localparam int NUM_BANKS = 4;

	// data widths
	localparam int PSUM_W = 16;
	localparam int ROW_W = NUM_BANKS * PSUM_W;

	typedef logic [PSUM_W-1:0] psum_word_t;
	typedef logic [ROW_W-1:0] psum_row_t;
	typedef logic [GLB_ADDR_W-1:0] glb_addr_t;
	typedef logic [ROW_ADDR_W-1:0] row_addr_t;

	// one update from the PE array
	typedef struct packed {
		glb_addr_t addr;
		psum_word_t value;
		logic first;
	} psum_item_t;

	// one row on the drain output
	typedef struct packed {
		psum_row_t row;
		logic last;
	} drain_beat_t;

	typedef enum logic {
		idle,
		run
	} drain_state_t;

endpackage

// File: hdl/dual_bram.sv
`timescale 1ns/1ps

module dual_bram #(
	parameter int DEPTH = 256,
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
)(
	input logic clk,

	input logic we_a,
	input logic re_a,
	input logic [AW-1:0] addr_a,
	input psum_pkg::psum_word_t wdata_a,
	output psum_pkg::psum_word_t rdata_a,

	input logic we_b,
	input logic re_b,
	input logic [AW-1:0] addr_b,
	input psum_pkg::psum_word_t wdata_b,
	output psum_pkg::psum_word_t rdata_b
);
	import psum_pkg::*;

	psum_word_t mem [DEPTH];

	// read before write on both ports
	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		if (re_a)
			rdata_a <= mem[addr_a];
		if (we_b)
			mem[addr_b] <= wdata_b;
		if (re_b)
			rdata_b <= mem[addr_b];
	end

endmodule

// File: hdl/psum_glb.sv
`timescale 1ns/1ps

module psum_glb #(
	parameter int DEPTH = 1024
)(
	input logic clk,

	// wide row reads
	input logic re_a,
	input psum_pkg::row_addr_t row_a,
	output psum_pkg::psum_row_t rdata_a,

	// word read / write
	input logic re_b,
	input logic we_b,
	input psum_pkg::glb_addr_t addr_b,
	input psum_pkg::psum_word_t wdata_b,
	output psum_pkg::psum_word_t rdata_b
);
	import psum_pkg::*;

	localparam int BANK_DEPTH = DEPTH / NUM_BANKS;
	localparam int BANK_AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

	glb_addr_t addr_b_q;
	psum_word_t bank_rdata_a [NUM_BANKS];
	psum_word_t bank_rdata_b [NUM_BANKS];

	// word address of the previous cycle, selects read data and write target
	always_ff @(posedge clk)
	begin
		addr_b_q <= addr_b;
	end

	// a bank port has a single address, so the word read uses the bank's
	// port B at addr_b while the write lands through port A at addr_b_q
	for (genvar k = 0; k < NUM_BANKS; k++)
	begin : g_bank
		logic wr_sel;
		logic rd_sel;
		logic [BANK_AW-1:0] port_a_addr;

		assign wr_sel = we_b && (addr_b_q[1:0] == 2'(k));
		assign rd_sel = re_b && (addr_b[1:0] == 2'(k));
		assign port_a_addr = wr_sel ? addr_b_q[BANK_AW+1:2] : row_a[BANK_AW-1:0];

		dual_bram #(
			.DEPTH(BANK_DEPTH)
		) bank_i (
			.clk(clk),
			.we_a(wr_sel),
			.re_a(re_a && !wr_sel),
			.addr_a(port_a_addr),
			.wdata_a(wdata_b),
			.rdata_a(bank_rdata_a[k]),
			.we_b(1'b0),
			.re_b(rd_sel),
			.addr_b(addr_b[BANK_AW+1:2]),
			.wdata_b('0),
			.rdata_b(bank_rdata_b[k])
		);
	end

	// word k of a row at bits 16k+15:16k
	always_comb
	begin
		for (int k = 0; k < NUM_BANKS; k++)
		begin
			rdata_a[PSUM_W*k +: PSUM_W] = bank_rdata_a[k];
		end
	end

	assign rdata_b = bank_rdata_b[addr_b_q[1:0]];

endmodule

// File: hdl/psum_accum.sv
`timescale 1ns/1ps

module psum_accum (
	input logic clk,
	input logic rst,

	input logic in_valid,
	input psum_pkg::psum_item_t in_item,

	output logic re_b,
	output logic we_b,
	output psum_pkg::glb_addr_t addr_b,
	output psum_pkg::psum_word_t wdata_b,
	input psum_pkg::psum_word_t rdata_b
);
	import psum_pkg::*;

	// stage 1 holds the item whose old value arrives this cycle
	logic s1_valid;
	psum_item_t s1_item;

	// last written sum, kept for forwarding
	logic wr_valid;
	glb_addr_t wr_addr;
	psum_word_t wr_sum;

	logic fwd_hit;
	psum_word_t old_value;
	psum_word_t sum;

	// stage 0
	assign re_b = in_valid;
	assign addr_b = in_item.addr;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			wr_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			wr_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_item <= in_item;
		wr_addr <= s1_item.addr;
		wr_sum <= sum;
	end

	// read was issued while the previous sum to this word was still being written
	assign fwd_hit = wr_valid && (wr_addr == s1_item.addr);
	assign old_value = fwd_hit ? wr_sum : rdata_b;

	// wraps modulo 2^16
	assign sum = s1_item.first ? s1_item.value : old_value + s1_item.value;

	// the buffer writes to the address presented in the previous cycle
	assign we_b = s1_valid;
	assign wdata_b = sum;

endmodule

// File: hdl/psum_drain.sv
`timescale 1ns/1ps

module psum_drain #(
	parameter int DRAIN_CREDITS = 4
)(
	input logic clk,
	input logic rst,

	input logic drain_start,
	input psum_pkg::row_addr_t drain_rows,
	output logic busy,

	output logic re_a,
	output psum_pkg::row_addr_t row_a,
	input psum_pkg::psum_row_t rdata_a,

	output logic out_valid,
	output psum_pkg::drain_beat_t out_beat,
	input logic out_credit
);
	import psum_pkg::*;

	localparam int CW = $clog2(DRAIN_CREDITS + 1);

	drain_state_t state;
	row_addr_t row_cnt;
	row_addr_t last_row;
	logic all_issued;
	logic [CW-1:0] credit_cnt;
	logic issue;
	logic rd_q;
	logic last_q;

	assign issue = (state == run) && !all_issued && (credit_cnt != '0);
	assign re_a = issue;
	assign row_a = row_cnt;
	assign busy = (state == run);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			row_cnt <= '0;
			all_issued <= 1'b0;
			credit_cnt <= CW'(DRAIN_CREDITS);
			rd_q <= 1'b0;
			last_q <= 1'b0;
		end
		else
		begin
			credit_cnt <= credit_cnt - CW'(issue) + CW'(out_credit);
			rd_q <= issue;
			last_q <= issue && (row_cnt == last_row);
			if (state == idle)
			begin
				if (drain_start)
				begin
					state <= run;
					row_cnt <= '0;
					all_issued <= 1'b0;
				end
			end
			else
			begin
				if (issue)
				begin
					row_cnt <= row_cnt + 1'b1;
					if (row_cnt == last_row)
						all_issued <= 1'b1;
				end
				// final beat leaves this cycle
				if (rd_q && last_q)
					state <= idle;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && drain_start)
			last_row <= drain_rows;
	end

	assign out_valid = rd_q;

	always_comb
	begin
		out_beat.row = rdata_a;
		out_beat.last = last_q;
	end

endmodule

// File: hdl/psum_top.sv
`timescale 1ns/1ps

module psum_top #(
	parameter int DEPTH = 1024,
	parameter int DRAIN_CREDITS = 4
)(
	input logic clk,
	input logic rst,

	input logic in_valid,
	input psum_pkg::psum_item_t in_item,

	input logic drain_start,
	input psum_pkg::row_addr_t drain_rows,
	output logic busy,

	output logic out_valid,
	output psum_pkg::drain_beat_t out_beat,
	input logic out_credit
);
	import psum_pkg::*;

	// accumulator side
	logic re_b;
	logic we_b;
	glb_addr_t addr_b;
	psum_word_t wdata_b;
	psum_word_t rdata_b;

	// drain side
	logic re_a;
	row_addr_t row_a;
	psum_row_t rdata_a;

	psum_accum psum_accum_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_item(in_item),
		.re_b(re_b),
		.we_b(we_b),
		.addr_b(addr_b),
		.wdata_b(wdata_b),
		.rdata_b(rdata_b)
	);

	psum_drain #(
		.DRAIN_CREDITS(DRAIN_CREDITS)
	) psum_drain_i (
		.clk(clk),
		.rst(rst),
		.drain_start(drain_start),
		.drain_rows(drain_rows),
		.busy(busy),
		.re_a(re_a),
		.row_a(row_a),
		.rdata_a(rdata_a),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_credit(out_credit)
	);

	psum_glb #(
		.DEPTH(DEPTH)
	) psum_glb_i (
		.clk(clk),
		.re_a(re_a),
		.row_a(row_a),
		.rdata_a(rdata_a),
		.re_b(re_b),
		.we_b(we_b),
		.addr_b(addr_b),
		.wdata_b(wdata_b),
		.rdata_b(rdata_b)
	);

endmodule

// File: sim/psum_tb.sv
`timescale 1ns/1ps

module psum_tb;
	import psum_pkg::*;

	localparam int DEPTH = 1024;
	localparam int DRAIN_CREDITS = 4;

	// test sizes
	localparam int NUM_ROWS = 16;
	localparam int NUM_WORDS = NUM_ROWS * NUM_BANKS;
	localparam int ACC_ITEMS = 256;
	localparam int RUNS = 24;
	localparam int MAX_RUN = 5;
	localparam int PAIRS = 16;
	localparam int PAIR_LEN = 6;
	localparam int MAX_ITEMS = NUM_WORDS + ACC_ITEMS + RUNS * MAX_RUN + PAIRS * PAIR_LEN;
	localparam int DRAINED_ROWS = 4 * NUM_ROWS + 7;
	localparam int WATCHDOG_CYCLES = MAX_ITEMS + 8 * DRAINED_ROWS + 2000;

	logic clk;
	logic rst;
	logic in_valid;
	psum_item_t in_item;
	logic drain_start;
	row_addr_t drain_rows;
	logic busy;
	logic out_valid;
	drain_beat_t out_beat;
	logic out_credit;

	// reference model of the buffer
	psum_word_t model [DEPTH];
	logic model_valid [DEPTH];

	int seed;

	// rows the drain should deliver, in order
	psum_row_t exp_rows [$];
	logic exp_last [$];
	int exp_index [$];

	// beats taken by the sink, waiting for compare
	psum_row_t rx_rows [$];
	logic rx_last [$];

	// credit return schedule, in cycles
	int due_q [$];
	int cyc;
	int credits_held;
	int beats_seen;

	psum_top #(
		.DEPTH(DEPTH),
		.DRAIN_CREDITS(DRAIN_CREDITS)
	) psum_top_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_item(in_item),
		.drain_start(drain_start),
		.drain_rows(drain_rows),
		.busy(busy),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_credit(out_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failed check");
	endtask

	task automatic check_row(input string name, input psum_row_t got, input psum_row_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	// word k of a row holds word address row*4+k
	function automatic psum_row_t expected_row(input row_addr_t r);
		psum_row_t row;
		int a;
		row = '0;
		for (int k = 0; k < NUM_BANKS; k++)
		begin
			a = int'(r) * NUM_BANKS + k;
			row[PSUM_W*k +: PSUM_W] = model[a];
		end
		return row;
	endfunction

	task automatic send_item(input glb_addr_t addr, input psum_word_t value, input logic first);
		psum_item_t item;
		item.addr = addr;
		item.value = value;
		item.first = first;
		@(posedge clk);
		in_valid <= 1'b1;
		in_item <= item;
		// sums wrap at 16 bits
		if (first)
			model[addr] = value;
		else
			model[addr] = model[addr] + value;
		model_valid[addr] = 1'b1;
	endtask

	// let the accumulator pipeline empty before a drain
	task automatic finish_items();
		@(posedge clk);
		in_valid <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic run_drain(input row_addr_t last_row, input logic retry_start);
		int limit;
		int waited;
		int r;
		int a;
		limit = 8 * (int'(last_row) + 1) + 50;
		for (r = 0; r <= int'(last_row); r++)
		begin
			for (a = r * NUM_BANKS; a < (r + 1) * NUM_BANKS; a++)
			begin
				if (!model_valid[a])
				begin
					$display("row %0d is drained before all of its words were written", r);
					report_failure();
				end
			end
			exp_rows.push_back(expected_row(row_addr_t'(r)));
			exp_last.push_back(r == int'(last_row));
			exp_index.push_back(r);
		end
		beats_seen = 0;

		@(posedge clk);
		drain_start <= 1'b1;
		drain_rows <= last_row;
		@(posedge clk);
		drain_start <= 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b1);

		// a second start while busy must be ignored
		if (retry_start)
		begin
			@(posedge clk);
			drain_start <= 1'b1;
			drain_rows <= row_addr_t'(3);
			@(posedge clk);
			drain_start <= 1'b0;
		end

		waited = 0;
		while (beats_seen < int'(last_row) + 1)
		begin
			@(posedge clk);
			waited = waited + 1;
			if (waited > limit)
			begin
				$display("drain of %0d rows did not finish within %0d cycles",
					int'(last_row) + 1, limit);
				report_failure();
			end
		end
		@(negedge clk);
		check_flag("busy", busy, 1'b0);

		waited = 0;
		while (due_q.size() > 0)
		begin
			@(negedge clk);
			waited = waited + 1;
			if (waited > 16)
			begin
				$display("sink did not return all of its credits");
				report_failure();
			end
		end
		repeat (2) @(negedge clk);

		if (exp_rows.size() != 0)
		begin
			$display("%0d expected rows never arrived", exp_rows.size());
			report_failure();
		end

		// no second drain may follow
		if (retry_start)
		begin
			repeat (20)
			begin
				@(negedge clk);
				check_flag("busy", busy, 1'b0);
			end
		end
	endtask

	// sink takes every beat and tracks the credits it holds
	always @(negedge clk)
	begin : beat_sink
		int delay;
		if (out_valid)
		begin
			check_flag("credit_held", credits_held > 0, 1'b1);
			check_flag("busy", busy, 1'b1);
			credits_held = credits_held - 1;
			beats_seen = beats_seen + 1;
			rx_rows.push_back(out_beat.row);
			rx_last.push_back(out_beat.last);
			delay = $unsigned($random(seed)) % 4;
			due_q.push_back(cyc + 1 + delay);
		end
		if (out_credit)
			credits_held = credits_held + 1;
	end

	// one credit back per cycle at most
	initial
	begin : credit_return
		int idx;
		logic give;
		out_credit = 1'b0;
		cyc = 0;
		forever
		begin
			@(posedge clk);
			cyc = cyc + 1;
			give = 1'b0;
			idx = 0;
			while (idx < due_q.size() && !give)
			begin
				if (due_q[idx] <= cyc)
				begin
					due_q.delete(idx);
					give = 1'b1;
				end
				else
					idx = idx + 1;
			end
			out_credit <= give;
		end
	end

	always @(posedge clk)
	begin : beat_compare
		psum_row_t got_row;
		logic got_last;
		while (rx_rows.size() > 0)
		begin
			got_row = rx_rows.pop_front();
			got_last = rx_last.pop_front();
			if (exp_rows.size() == 0)
			begin
				$display("a beat arrived while no row was expected");
				report_failure();
			end
			else
			begin
				check_row($sformatf("out_beat.row of row %0d", exp_index[0]),
					got_row, exp_rows[0]);
				check_flag($sformatf("out_beat.last of row %0d", exp_index[0]),
					got_last, exp_last[0]);
				void'(exp_rows.pop_front());
				void'(exp_last.pop_front());
				void'(exp_index.pop_front());
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		report_failure();
	end

	initial
	begin
		int i;
		int n;
		int len;
		glb_addr_t addr;
		glb_addr_t addr_alt;

		seed = 32'h1824_0889;
		rst = 1'b1;
		in_valid = 1'b0;
		in_item = '0;
		drain_start = 1'b0;
		drain_rows = '0;
		credits_held = DRAIN_CREDITS;
		beats_seen = 0;
		for (i = 0; i < DEPTH; i++)
		begin
			model[i] = '0;
			model_valid[i] = 1'b0;
		end

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("out_valid", out_valid, 1'b0);

		// every word of rows 0 to 15 overwritten
		for (i = 0; i < NUM_WORDS; i++)
			send_item(glb_addr_t'(i), psum_word_t'($random(seed)), 1'b1);
		finish_items();
		run_drain(row_addr_t'(NUM_ROWS - 1), 1'b0);

		// random accumulation
		for (i = 0; i < ACC_ITEMS; i++)
		begin
			addr = glb_addr_t'($unsigned($random(seed)) % NUM_WORDS);
			send_item(addr, psum_word_t'($random(seed)), 1'b0);
		end
		finish_items();
		run_drain(row_addr_t'(NUM_ROWS - 1), 1'b0);

		// runs to one word, some restarted by a first item
		for (n = 0; n < RUNS; n++)
		begin
			addr = glb_addr_t'($unsigned($random(seed)) % NUM_WORDS);
			len = 2 + $unsigned($random(seed)) % (MAX_RUN - 1);
			for (i = 0; i < len; i++)
				send_item(addr, psum_word_t'($random(seed)), (i == 1) && (n % 4 == 0));
		end
		// ping-pong between neighbouring banks of one row
		for (n = 0; n < PAIRS; n++)
		begin
			addr = glb_addr_t'($unsigned($random(seed)) % NUM_WORDS);
			addr_alt = {addr[GLB_ADDR_W-1:2], addr[1:0] + 2'd1};
			for (i = 0; i < PAIR_LEN; i++)
				send_item((i % 2 == 0) ? addr : addr_alt, psum_word_t'($random(seed)), 1'b0);
		end
		finish_items();
		run_drain(row_addr_t'(NUM_ROWS - 1), 1'b0);

		// framing with short drains and a start while busy
		run_drain(row_addr_t'(0), 1'b0);
		run_drain(row_addr_t'(5), 1'b0);
		run_drain(row_addr_t'(NUM_ROWS - 1), 1'b1);

		@(posedge clk);
		if (credits_held != DRAIN_CREDITS || exp_rows.size() != 0)
		begin
			$display("sink holds %0d credits with %0d rows outstanding at the end of the run",
				credits_held, exp_rows.size());
			report_failure();
		end
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// File: sources.f
hdl/psum_pkg.sv
hdl/dual_bram.sv
hdl/psum_glb.sv
hdl/psum_accum.sv
hdl/psum_drain.sv
hdl/psum_top.sv
sim/psum_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the partial-sum buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module psum_tb \
	-f sources.f --Mdir obj_dir -o psum_sim; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/psum_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_out"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
